//--- common/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int unsigned XLEN = 32;     // Fixed by the instruction set

    // Primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;

    localparam logic [5:0] FUNCT_JR   = 6'h08;  // Under SPECIAL

    // REGIMM rt selects
    localparam logic [4:0] RT_BLTZ    = 5'h00;
    localparam logic [4:0] RT_BGEZ    = 5'h01;

    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_BEQ  = 4'd1,
        BR_BNE  = 4'd2,
        BR_BGEZ = 4'd3,
        BR_BGTZ = 4'd4,
        BR_BLEZ = 4'd5,
        BR_BLTZ = 4'd6,
        BR_J    = 4'd7,
        BR_JAL  = 4'd8,
        BR_JR   = 4'd9
    } branchCodeE;

    // I-format view, funct sits in imm[5:0] for R-format
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } instrIS;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index;
    } instrJS;

    typedef union packed {
        instrIS iFmt;
        instrJS jFmt;
    } instrWordU;

    typedef struct packed {
        logic        isBranch;
        branchCodeE  branchCode;
        logic [15:0] immOffset;
        logic [25:0] jumpIndex;
    } branchTypeS;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        instrWordU       instr;
        logic [XLEN-1:0] rsVal;
        logic [XLEN-1:0] rtVal;
    } exIssueS;

    typedef struct packed {
        logic            flush;
        logic [XLEN-1:0] target;
    } redirectS;

    typedef struct packed {
        logic resolved;
        logic taken;
        logic mispredict;
    } branchEventS;

    // Static prediction assumed by fetch
    typedef enum logic [0:0] {
        NOT_TAKEN = 1'b0,
        BTFN      = 1'b1     // Backward taken, forward not taken
    } policyE;

endpackage

`default_nettype wire

//--- common/busPkg.sv
`default_nettype none

package busPkg;

    localparam int unsigned CSR_ADDR_W = 8;
    localparam int unsigned CSR_DATA_W = 32;

    // Register map
    localparam logic [CSR_ADDR_W-1:0] CSR_CTRL       = 8'h00;
    localparam logic [CSR_ADDR_W-1:0] CSR_RESOLVED   = 8'h04;
    localparam logic [CSR_ADDR_W-1:0] CSR_TAKEN      = 8'h08;
    localparam logic [CSR_ADDR_W-1:0] CSR_MISPREDICT = 8'h0C;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic                    awvalid;
        logic [CSR_ADDR_W-1:0]   awaddr;
        logic                    wvalid;
        logic [CSR_DATA_W-1:0]   wdata;
        logic [CSR_DATA_W/8-1:0] wstrb;
        logic                    bready;
        logic                    arvalid;
        logic [CSR_ADDR_W-1:0]   araddr;
        logic                    rready;
    } axiLiteReqS;

    typedef struct packed {
        logic                  awready;
        logic                  wready;
        logic                  bvalid;
        logic [1:0]            bresp;
        logic                  arready;
        logic                  rvalid;
        logic [CSR_DATA_W-1:0] rdata;
        logic [1:0]            rresp;
    } axiLiteRspS;

endpackage

`default_nettype wire

//--- branch/branchDecode.sv
`timescale 1ns/1ps
`default_nettype none

module branchDecode import cpuPkg::*; (
    input  instrWordU  instr,
    output branchTypeS brType
);

    branchCodeE code;

    always_comb begin
        code = BR_NONE;
        case (instr.iFmt.opcode)
            OP_BEQ:  code = BR_BEQ;
            OP_BNE:  code = BR_BNE;
            OP_BLEZ: code = BR_BLEZ;
            OP_BGTZ: code = BR_BGTZ;
            OP_J:    code = BR_J;
            OP_JAL:  code = BR_JAL;
            OP_REGIMM: begin
                // rt picks the compare-with-zero flavour
                case (instr.iFmt.rt)
                    RT_BLTZ: code = BR_BLTZ;
                    RT_BGEZ: code = BR_BGEZ;
                    default: code = BR_NONE;
                endcase
            end
            OP_SPECIAL: begin
                if (instr.iFmt.imm[5:0] == FUNCT_JR) begin
                    code = BR_JR;
                end
            end
            default: code = BR_NONE;
        endcase
    end

    always_comb begin
        brType.isBranch   = (code != BR_NONE);
        brType.branchCode = code;
        brType.immOffset  = instr.iFmt.imm;    // Word offset, unscaled
        brType.jumpIndex  = instr.jFmt.index;
    end

endmodule

`default_nettype wire

//--- branch/branchResolve.sv
`timescale 1ns/1ps
`default_nettype none

module branchResolve import cpuPkg::*; (
    input  branchTypeS      brType,
    input  logic [XLEN-1:0] rsVal,
    input  logic [XLEN-1:0] rtVal,
    output logic            taken
);

    logic signed [XLEN-1:0] rsSigned;

    assign rsSigned = $signed(rsVal);   // Zero compares are signed

    always_comb begin
        taken = 1'b0;
        case (brType.branchCode)
            BR_BEQ: begin
                taken = (rsVal == rtVal);
            end
            BR_BNE: begin
                taken = (rsVal != rtVal);
            end
            BR_BGEZ: begin
                taken = (rsSigned >= 0);
            end
            BR_BGTZ: begin
                taken = (rsSigned > 0);
            end
            BR_BLEZ: begin
                taken = (rsSigned <= 0);
            end
            BR_BLTZ: begin
                taken = (rsSigned < 0);
            end
            BR_J, BR_JAL, BR_JR: begin
                taken = 1'b1;          // Unconditional
            end
            default: begin
                taken = 1'b0;
            end
        endcase

        if (!brType.isBranch) begin
            taken = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- branch/branchRedirect.sv
`timescale 1ns/1ps
`default_nettype none

module branchRedirect import cpuPkg::*; (
    input  logic            clk,
    input  logic            rstN,
    input  logic            issueValid,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rsVal,      // JR target
    input  branchTypeS      brType,
    input  logic            taken,
    input  policyE          policy,
    output redirectS        redirect,
    output branchEventS     brEvent
);

    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] pcPlus8;
    logic [XLEN-1:0] condTarget;
    logic [XLEN-1:0] jumpTarget;
    logic [XLEN-1:0] takenTarget;
    logic [XLEN-1:0] nextTarget;
    logic            isCond;
    logic            predTaken;
    logic            mispredict;
    logic            fire;
    logic            flushQ;
    logic [XLEN-1:0] targetQ;

    assign pcPlus4    = pc + 32'd4;
    assign pcPlus8    = pc + 32'd8;   // Skips the delay slot
    assign condTarget = pcPlus4 + {{14{brType.immOffset[15]}}, brType.immOffset, 2'b00};
    assign jumpTarget = {pcPlus4[31:28], brType.jumpIndex, 2'b00};

    always_comb begin
        case (brType.branchCode)
            BR_J, BR_JAL: takenTarget = jumpTarget;
            BR_JR:        takenTarget = rsVal;
            default:      takenTarget = condTarget;
        endcase
    end

    assign isCond = brType.isBranch &&
                    !(brType.branchCode inside {BR_J, BR_JAL, BR_JR});

    // Fetch never predicts jumps, only backward conditionals under BTFN
    assign predTaken  = (policy == BTFN) && isCond && brType.immOffset[15];
    assign mispredict = brType.isBranch && (taken != predTaken);
    assign nextTarget = taken ? takenTarget : pcPlus8;
    assign fire       = issueValid && brType.isBranch;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            flushQ  <= 1'b0;
            brEvent <= '0;
        end else begin
            flushQ  <= fire && mispredict;
            brEvent <= '{resolved:   fire,
                         taken:      fire && taken,
                         mispredict: fire && mispredict};
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            targetQ <= nextTarget;
        end
    end

    assign redirect = '{flush: flushQ, target: targetQ};

    // Every flush must also be counted as a resolved branch
    assert property (@(posedge clk) disable iff (!rstN)
        redirect.flush |-> brEvent.resolved)
        else $error("branchRedirect: flush without resolved event");

endmodule

`default_nettype wire

//--- rtl/branchCsr.sv
`timescale 1ns/1ps
`default_nettype none

module branchCsr import cpuPkg::*, busPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  axiLiteReqS  csrReq,
    output axiLiteRspS  csrRsp,
    input  branchEventS brEvent,
    output policyE      policy
);

    logic                  wrAccept;
    logic                  rdAccept;
    logic                  wrCtrl;
    logic                  wrCounter;
    logic                  bvalidQ;
    logic [1:0]            brespQ;
    logic                  rvalidQ;
    logic [1:0]            rrespQ;
    logic [CSR_DATA_W-1:0] rdataQ;
    logic [CSR_DATA_W-1:0] rdMux;
    logic                  rdMapped;
    policyE                policyQ;
    logic [CSR_DATA_W-1:0] resolvedCnt;
    logic [CSR_DATA_W-1:0] takenCnt;
    logic [CSR_DATA_W-1:0] mispredictCnt;

    function automatic logic [CSR_DATA_W-1:0] satInc(input logic [CSR_DATA_W-1:0] cnt,
                                                     input logic hit);
        if (hit && (cnt != '1)) begin
            return cnt + 1'b1;
        end
        return cnt;
    endfunction

    // Address and data taken together, one write in flight
    assign wrAccept  = csrReq.awvalid && csrReq.wvalid && !bvalidQ;
    assign rdAccept  = csrReq.arvalid && !rvalidQ;
    assign wrCtrl    = (csrReq.awaddr == CSR_CTRL);
    assign wrCounter = csrReq.awaddr inside {CSR_RESOLVED, CSR_TAKEN, CSR_MISPREDICT};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bvalidQ <= 1'b0;
            brespQ  <= RESP_OKAY;
        end else if (wrAccept) begin
            bvalidQ <= 1'b1;
            brespQ  <= (wrCtrl || wrCounter) ? RESP_OKAY : RESP_SLVERR;
        end else if (csrReq.bready) begin
            bvalidQ <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            policyQ <= NOT_TAKEN;
        end else if (wrAccept && wrCtrl && csrReq.wstrb[0]) begin
            policyQ <= policyE'(csrReq.wdata[0]);
        end
    end

    // A write to any counter offset clears all three
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resolvedCnt   <= '0;
            takenCnt      <= '0;
            mispredictCnt <= '0;
        end else if (wrAccept && wrCounter) begin
            resolvedCnt   <= '0;
            takenCnt      <= '0;
            mispredictCnt <= '0;
        end else begin
            resolvedCnt   <= satInc(resolvedCnt, brEvent.resolved);
            takenCnt      <= satInc(takenCnt, brEvent.taken);
            mispredictCnt <= satInc(mispredictCnt, brEvent.mispredict);
        end
    end

    always_comb begin
        rdMapped = 1'b1;
        rdMux    = '0;
        case (csrReq.araddr)
            CSR_CTRL:       rdMux = {{(CSR_DATA_W-1){1'b0}}, policyQ};
            CSR_RESOLVED:   rdMux = resolvedCnt;
            CSR_TAKEN:      rdMux = takenCnt;
            CSR_MISPREDICT: rdMux = mispredictCnt;
            default:        rdMapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rvalidQ <= 1'b0;
            rrespQ  <= RESP_OKAY;
        end else if (rdAccept) begin
            rvalidQ <= 1'b1;
            rrespQ  <= rdMapped ? RESP_OKAY : RESP_SLVERR;
        end else if (csrReq.rready) begin
            rvalidQ <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rdAccept) begin
            rdataQ <= rdMux;   // Held while rready is low
        end
    end

    assign policy = policyQ;
    assign csrRsp = '{awready: wrAccept,
                      wready:  wrAccept,
                      bvalid:  bvalidQ,
                      bresp:   brespQ,
                      arready: rdAccept,
                      rvalid:  rvalidQ,
                      rdata:   rdataQ,
                      rresp:   rrespQ};

    assert property (@(posedge clk) disable iff (!rstN)
        csrRsp.bvalid && !csrReq.bready |=> csrRsp.bvalid)
        else $error("branchCsr: bvalid dropped before bready");

    assert property (@(posedge clk) disable iff (!rstN)
        csrRsp.rvalid && !csrReq.rready |=> csrRsp.rvalid)
        else $error("branchCsr: rvalid dropped before rready");

endmodule

`default_nettype wire

//--- rtl/branchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module branchUnit import cpuPkg::*, busPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  exIssueS    issue,
    output redirectS   redirect,
    input  axiLiteReqS csrReq,
    output axiLiteRspS csrRsp
);

    branchTypeS  brType;
    logic        taken;
    policyE      policy;
    branchEventS brEvent;

    branchDecode i_branchDecode (
        .instr  (issue.instr),
        .brType (brType)
    );

    branchResolve i_branchResolve (
        .brType (brType),
        .rsVal  (issue.rsVal),
        .rtVal  (issue.rtVal),
        .taken  (taken)
    );

    // Single register stage between issue and fetch
    branchRedirect i_branchRedirect (
        .clk        (clk),
        .rstN       (rstN),
        .issueValid (issue.valid),
        .pc         (issue.pc),
        .rsVal      (issue.rsVal),
        .brType     (brType),
        .taken      (taken),
        .policy     (policy),
        .redirect   (redirect),
        .brEvent    (brEvent)
    );

    branchCsr i_branchCsr (
        .clk     (clk),
        .rstN    (rstN),
        .csrReq  (csrReq),
        .csrRsp  (csrRsp),
        .brEvent (brEvent),
        .policy  (policy)
    );

endmodule

`default_nettype wire

//--- tb/tbBranchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module tbBranchUnit import cpuPkg::*, busPkg::*; ;

    localparam int TIMEOUT = 50;   // Cycles per handshake wait

    typedef struct packed {
        logic        flush;
        logic [31:0] target;
        logic        resolved;
        logic        taken;
        logic        mispredict;
    } expS;

    logic        clk;
    logic        rstN;
    exIssueS     issue;
    redirectS    redirect;
    axiLiteReqS  csrReq;
    axiLiteRspS  csrRsp;

    logic        modelPolicy;
    logic        pendValid;
    expS         pendExp;
    logic [31:0] rngState;
    int unsigned modelResolved;
    int unsigned modelTaken;
    int unsigned modelMispredict;
    int          errorCount;
    int          checkCount;
    string       testName;

    branchUnit i_branchUnit (
        .clk      (clk),
        .rstN     (rstN),
        .issue    (issue),
        .redirect (redirect),
        .csrReq   (csrReq),
        .csrRsp   (csrRsp)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    // Expected redirect and events for one issued word
    function automatic expS refBranch(input logic [31:0] pc, input logic [31:0] instr,
                                      input logic [31:0] rsVal, input logic [31:0] rtVal,
                                      input logic policy);
        expS         e;
        logic        isBr;
        logic        isCond;
        logic        tk;
        logic        pred;
        logic [31:0] tgt;
        isBr   = 1'b1;
        isCond = 1'b1;
        tk     = 1'b0;
        tgt    = pc + 32'd4 + {{14{instr[15]}}, instr[15:0], 2'b00};
        case (instr[31:26])
            OP_BEQ:  tk = (rsVal == rtVal);
            OP_BNE:  tk = (rsVal != rtVal);
            OP_BLEZ: tk = rsVal[31] || (rsVal == 32'd0);
            OP_BGTZ: tk = !rsVal[31] && (rsVal != 32'd0);
            OP_REGIMM: begin
                if (instr[20:16] == RT_BLTZ) begin
                    tk = rsVal[31];
                end else if (instr[20:16] == RT_BGEZ) begin
                    tk = !rsVal[31];
                end else begin
                    isBr = 1'b0;
                end
            end
            OP_J, OP_JAL: begin
                isCond = 1'b0;
                tk     = 1'b1;
                tgt    = {pc[31:28] + {3'b000, (pc[27:0] > 28'hFFFFFFB)}, instr[25:0], 2'b00};
            end
            OP_SPECIAL: begin
                if (instr[5:0] == FUNCT_JR) begin
                    isCond = 1'b0;
                    tk     = 1'b1;
                    tgt    = rsVal;
                end else begin
                    isBr = 1'b0;
                end
            end
            default: isBr = 1'b0;
        endcase
        pred         = policy && isCond && instr[15];   // Backward when offset negative
        e.resolved   = isBr;
        e.taken      = isBr && tk;
        e.mispredict = isBr && (tk != pred);
        e.flush      = e.mispredict;
        e.target     = tk ? tgt : pc + 32'd8;
        return e;
    endfunction

    task automatic checkEq(input string what, input logic [31:0] expVal,
                           input logic [31:0] actVal);
        checkCount++;
        assert (expVal === actVal) else begin
            errorCount++;
            $display("Error %s %s: expected %h actual %h", testName, what, expVal, actVal);
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("Timeout in %s while waiting for %s", testName, what);
        $display("Test failed");
        $finish;
    endtask

    // Capture the issue that the DUT registers on this edge
    always @(posedge clk) begin
        pendValid <= rstN && issue.valid;
        pendExp   <= refBranch(issue.pc, issue.instr, issue.rsVal, issue.rtVal, modelPolicy);
    end

    always @(negedge clk) begin
        if (rstN) begin
            checkEq("flush", {31'd0, pendValid && pendExp.flush}, {31'd0, redirect.flush});
            if (pendValid && pendExp.resolved) begin
                checkEq("target", pendExp.target, redirect.target);
                modelResolved   += 1;
                modelTaken      += pendExp.taken;
                modelMispredict += pendExp.mispredict;
            end
        end
    end

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic issueOne(input logic [31:0] pc, input logic [31:0] instr,
                            input logic [31:0] rs, input logic [31:0] rt);
        issue.valid = 1'b1;
        issue.pc    = pc;
        issue.instr = instr;
        issue.rsVal = rs;
        issue.rtVal = rt;
        @(posedge clk);
        #2;
        issue.valid = 1'b0;
    endtask

    task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
        int waitCnt;
        csrReq.awvalid = 1'b1;
        csrReq.awaddr  = addr;
        csrReq.wvalid  = 1'b1;
        csrReq.wdata   = data;
        csrReq.bready  = 1'b1;
        waitCnt = 0;
        @(negedge clk);
        while (!(csrRsp.awready && csrRsp.wready)) begin
            waitCnt++;
            if (waitCnt > TIMEOUT) timeoutFail("write address and data acceptance");
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        csrReq.awvalid = 1'b0;
        csrReq.wvalid  = 1'b0;
        waitCnt = 0;
        @(negedge clk);
        while (!csrRsp.bvalid) begin
            waitCnt++;
            if (waitCnt > TIMEOUT) timeoutFail("write response");
            @(negedge clk);
        end
        resp = csrRsp.bresp;
        @(posedge clk);
        #2;
        csrReq.bready = 1'b0;
    endtask

    // holdCycles keeps rready low after rvalid, checking rdata stays put
    task automatic axiRead(input logic [7:0] addr, input int holdCycles,
                           output logic [31:0] data, output logic [1:0] resp);
        int waitCnt;
        int i;
        csrReq.arvalid = 1'b1;
        csrReq.araddr  = addr;
        csrReq.rready  = (holdCycles == 0);
        waitCnt = 0;
        @(negedge clk);
        while (!csrRsp.arready) begin
            waitCnt++;
            if (waitCnt > TIMEOUT) timeoutFail("read address acceptance");
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        csrReq.arvalid = 1'b0;
        waitCnt = 0;
        @(negedge clk);
        while (!csrRsp.rvalid) begin
            waitCnt++;
            if (waitCnt > TIMEOUT) timeoutFail("read data");
            @(negedge clk);
        end
        data = csrRsp.rdata;
        resp = csrRsp.rresp;
        for (i = 0; i < holdCycles; i++) begin
            @(negedge clk);
            checkEq("held rvalid", 32'd1, {31'd0, csrRsp.rvalid});
            checkEq("held rdata", data, csrRsp.rdata);
        end
        if (holdCycles > 0) begin
            @(posedge clk);
            #2;
            csrReq.rready = 1'b1;
        end
        @(posedge clk);
        #2;
        csrReq.rready = 1'b0;
    endtask

    task automatic writeReg(input logic [7:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axiWrite(addr, data, resp);
        checkEq("bresp", {30'd0, RESP_OKAY}, {30'd0, resp});
        if (addr == CSR_CTRL) begin
            modelPolicy = data[0];
        end else begin
            modelResolved   = 0;
            modelTaken      = 0;
            modelMispredict = 0;
        end
    endtask

    task automatic readCheck(input string what, input logic [7:0] addr,
                             input logic [31:0] expData, input logic [1:0] expResp);
        logic [31:0] data;
        logic [1:0]  resp;
        axiRead(addr, 0, data, resp);
        checkEq({what, " rresp"}, {30'd0, expResp}, {30'd0, resp});
        if (expResp == RESP_OKAY) begin
            checkEq(what, expData, data);
        end
    endtask

    task automatic checkCounters();
        idle(3);   // Let the last events reach the counters
        readCheck("RESOLVED", CSR_RESOLVED, modelResolved, RESP_OKAY);
        readCheck("TAKEN", CSR_TAKEN, modelTaken, RESP_OKAY);
        readCheck("MISPREDICT", CSR_MISPREDICT, modelMispredict, RESP_OKAY);
    endtask

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rt,
                                         input logic [15:0] imm);
        return {op, 5'd3, rt, imm};
    endfunction

    // Mix of branch kinds and other opcodes, selRange 9 gives branches only
    function automatic logic [31:0] randomInstr(input int unsigned selRange);
        logic [31:0] r;
        logic [31:0] w;
        r = nextRand();
        w = nextRand();
        case (r % selRange)
            0: w[31:26] = OP_BEQ;
            1: w[31:26] = OP_BNE;
            2: w[31:26] = OP_BLEZ;
            3: w[31:26] = OP_BGTZ;
            4: w = {OP_REGIMM, w[25:21], RT_BLTZ, w[15:0]};
            5: w = {OP_REGIMM, w[25:21], RT_BGEZ, w[15:0]};
            6: w[31:26] = OP_J;
            7: w[31:26] = OP_JAL;
            8: w = {OP_SPECIAL, w[25:6], FUNCT_JR};
            9: w[31:26] = OP_SPECIAL;
            10: w[31:26] = OP_REGIMM;
            default: w[31:26] = 6'h08 + {1'b0, r[12:8]};   // ALU and memory ops
        endcase
        return w;
    endfunction

    task automatic runRandom(input int count, input int unsigned selRange, input bit gaps);
        logic [31:0] pc;
        logic [31:0] rs;
        logic [31:0] rt;
        logic [31:0] ctl;
        repeat (count) begin
            pc  = nextRand() & 32'hFFFF_FFFC;
            rs  = nextRand();
            rt  = nextRand();
            ctl = nextRand();
            if (ctl[1:0] == 2'd0) rt = rs;      // Equal operands now and then
            if (ctl[3:2] == 2'd0) rs = 32'd0;
            issueOne(pc, randomInstr(selRange), rs, rt);
            if (gaps && ctl[5:4] == 2'd0) idle(ctl[7:6]);
        end
    endtask

    initial begin
        logic [31:0] pc;
        logic [31:0] rdData;
        logic [1:0]  rdResp;
        clk             = 1'b0;
        rstN            = 1'b0;
        issue           = '0;
        csrReq          = '0;
        csrReq.wstrb    = 4'hF;
        modelPolicy     = 1'b0;
        rngState        = 32'd57;
        modelResolved   = 0;
        modelTaken      = 0;
        modelMispredict = 0;
        errorCount      = 0;
        checkCount      = 0;
        testName        = "reset";
        repeat (5) @(posedge clk);
        #2;
        rstN = 1'b1;

        checkEq("flush after reset", 32'd0, {31'd0, redirect.flush});
        readCheck("CTRL", CSR_CTRL, 32'd0, RESP_OKAY);
        checkCounters();
        readCheck("unmapped", 8'h10, 32'd0, RESP_SLVERR);

        testName = "directed";
        pc = 32'h0000_1000;
        issueOne(pc, encI(OP_BEQ, 5'd4, 16'h0010), 32'd5, 32'd5);
        issueOne(pc, encI(OP_BEQ, 5'd4, 16'h0010), 32'd5, 32'd6);
        issueOne(pc, encI(OP_BNE, 5'd4, 16'hFF00), 32'd5, 32'd6);
        issueOne(pc, encI(OP_BNE, 5'd4, 16'hFF00), 32'd7, 32'd7);
        issueOne(pc, encI(OP_REGIMM, RT_BGEZ, 16'h0020), 32'd0, 32'd0);
        issueOne(pc, encI(OP_REGIMM, RT_BGEZ, 16'h0020), 32'h8000_0000, 32'd0);
        issueOne(pc, encI(OP_BGTZ, 5'd0, 16'h0008), 32'd0, 32'd0);
        issueOne(pc, encI(OP_BGTZ, 5'd0, 16'h0008), 32'h7FFF_FFFF, 32'd0);
        issueOne(pc, encI(OP_BLEZ, 5'd0, 16'hFFFC), 32'd0, 32'd0);
        issueOne(pc, encI(OP_BLEZ, 5'd0, 16'hFFFC), 32'h7FFF_FFFF, 32'd0);
        issueOne(pc, encI(OP_REGIMM, RT_BLTZ, 16'h0004), 32'h8000_0000, 32'd0);
        issueOne(pc, encI(OP_REGIMM, RT_BLTZ, 16'h0004), 32'd0, 32'd0);
        issueOne(32'hF000_0FF8, {OP_J, 26'h0ABCDE}, 32'd0, 32'd0);
        issueOne(pc, {OP_JAL, 26'h3FFFFFF}, 32'd0, 32'd0);
        issueOne(pc, {OP_SPECIAL, 5'd9, 15'd0, FUNCT_JR}, nextRand(), 32'd0);
        issueOne(pc, encI(6'h08, 5'd1, 16'h0001), 32'd0, 32'd0);   // ADDI, no branch
        idle(2);

        testName = "btfn";
        writeReg(CSR_CTRL, 32'd1);
        readCheck("CTRL", CSR_CTRL, 32'd1, RESP_OKAY);
        issueOne(pc, encI(OP_BEQ, 5'd4, 16'hFFF0), 32'd9, 32'd9);
        issueOne(pc, encI(OP_BEQ, 5'd4, 16'hFFF0), 32'd9, 32'd8);
        issueOne(pc, encI(OP_REGIMM, RT_BLTZ, 16'h8000), 32'd1, 32'd0);
        issueOne(pc, encI(OP_BNE, 5'd4, 16'h0040), 32'd1, 32'd2);
        issueOne(pc, encI(OP_BNE, 5'd4, 16'h0040), 32'd2, 32'd2);
        issueOne(pc, {OP_J, 26'h0000100}, 32'd0, 32'd0);
        idle(2);

        testName = "random";
        runRandom(150, 13, 1'b1);
        idle(1);
        writeReg(CSR_CTRL, 32'd0);
        runRandom(150, 13, 1'b1);

        testName = "counters";
        checkCounters();
        writeReg(CSR_TAKEN, 32'd0);
        checkCounters();

        testName = "read backpressure";
        fork
            runRandom(20, 9, 1'b0);
            axiRead(CSR_RESOLVED, 6, rdData, rdResp);
        join
        checkEq("held rresp", {30'd0, RESP_OKAY}, {30'd0, rdResp});
        checkCounters();

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
common/cpuPkg.sv
common/busPkg.sv
branch/branchDecode.sv
branch/branchResolve.sv
branch/branchRedirect.sv
rtl/branchCsr.sv
rtl/branchUnit.sv
tb/tbBranchUnit.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tbBranchUnit -f all.f -o simv \
    || exit 1
out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -q "^Test completed successfully$" && exit 0 || exit 1
